//--- rv_decoder_top.f
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/decode_ctrl_pkg.sv
rtl/ctrl_decode.sv
rtl/imm_gen.sv
rtl/rv_decoder_top.sv
tb/rv_decoder_assert.sv
tb/rv_decoder_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -Wno-fatal \
    --top-module rv_decoder_tb -f rv_decoder_top.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vrv_decoder_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1

//--- tb/rv_decoder_tb.sv
`timescale 1ns/1ps
`include "decoder_params.svh"

module rv_decoder_tb;
    import rv_isa_pkg::*;
    import decode_ctrl_pkg::*;

    localparam int NUM_TABLE   = 26;                     // directed words
    localparam int NUM_RAND    = 32;                     // random OP words
    localparam int NUM_TOTAL   = NUM_TABLE + NUM_RAND;
    localparam int WATCHDOG_NS = (4 + NUM_TABLE + NUM_RAND + 10) * 40;

    logic               clk;
    logic               reset;
    logic [`XLEN-1:0]   idata;
    decode_out_t        dec;

    logic [`XLEN-1:0]   word_tab [NUM_TOTAL];
    decode_out_t        exp_tab  [NUM_TOTAL];
    string              name_tab [NUM_TOTAL];
    int                 n_fill;
    int                 n_pass;
    int                 n_fail;

    rv_decoder_top DUT (.clk(clk), .reset(reset), .idata(idata), .dec(dec));

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                          // 40 ns period
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("STATUS: FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////
    // instruction encoders and expected bundles
    ////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'd99};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] off, logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'd111};
    endfunction

    function automatic decode_out_t make_exp(int rs1, int rs2, int rd, int alu, int wr,
                                             int shamt, logic [31:0] imm, int s1, int s2,
                                             int rds, int pcs);
        decode_out_t e;
        e.rs1     = rs1[4:0];
        e.rs2     = rs2[4:0];
        e.rd      = rd[4:0];
        e.alu_op  = alu_op_e'(alu[5:0]);
        e.wr      = wr[0];
        e.shamt   = shamt[4:0];
        e.imm     = imm;
        e.rs1_sel = rs1_sel_e'(s1[0]);
        e.rs2_sel = rs2_sel_e'(s2[0]);
        e.rd_sel  = rd_sel_e'(rds[1:0]);
        e.pc_sel  = pc_sel_e'(pcs[1:0]);
        return e;
    endfunction

    function automatic decode_out_t nop_exp();
        return make_exp(0, 0, 0, 0, 0, 0, 32'h0, 0, 0, 0, 3);   // pc sequential only
    endfunction

    // R-type expectation from funct3 and bit 30
    function automatic decode_out_t op_exp(logic [31:0] w);
        int alu;
        int rds;
        rds = 0;
        case (w[14:12])
            3'd0: alu = w[30] ? 10 : 1;
            3'd1: alu = 11;
            3'd2: begin
                alu = 2;
                rds = 2;
            end
            3'd3: begin
                alu = 3;
                rds = 2;
            end
            3'd4: alu = 4;
            3'd5: alu = w[30] ? 13 : 12;
            3'd6: alu = 5;
            default: alu = 6;
        endcase
        return make_exp(w[19:15], w[24:20], w[11:7], alu, 1, 0, 32'h0, 0, 0, rds, 3);
    endfunction

    task automatic add_entry(string name, logic [31:0] w, decode_out_t e);
        name_tab[n_fill] = name;
        word_tab[n_fill] = w;
        exp_tab[n_fill]  = e;
        n_fill++;
    endtask

    task automatic check_field(string test, string field, logic [31:0] e, logic [31:0] g,
                               inout int bad);
        if (e !== g) begin
            $display("ERROR %s: %s expected %h got %h", test, field, e, g);
            bad++;
        end
    endtask

    task automatic compare_dec(string test, decode_out_t e);
        int bad;
        bad = 0;
        check_field(test, "rs1", e.rs1, dec.rs1, bad);
        check_field(test, "rs2", e.rs2, dec.rs2, bad);
        check_field(test, "rd", e.rd, dec.rd, bad);
        check_field(test, "alu_op", e.alu_op, dec.alu_op, bad);
        check_field(test, "wr", e.wr, dec.wr, bad);
        check_field(test, "shamt", e.shamt, dec.shamt, bad);
        check_field(test, "imm", e.imm, dec.imm, bad);
        check_field(test, "rs1_sel", e.rs1_sel, dec.rs1_sel, bad);
        check_field(test, "rs2_sel", e.rs2_sel, dec.rs2_sel, bad);
        check_field(test, "rd_sel", e.rd_sel, dec.rd_sel, bad);
        check_field(test, "pc_sel", e.pc_sel, dec.pc_sel, bad);
        if (bad == 0) begin
            n_pass++;
            $display("test %s passed", test);
        end else begin
            n_fail++;
            $display("test %s failed with %0d field errors", test, bad);
        end
    endtask

    task automatic build_table();
        add_entry("zero_word", 32'h0, nop_exp());
        add_entry("bad_opcode", enc_r(7'd0, 5'd1, 5'd2, 3'd0, 5'd3, 7'h0b), nop_exp());
        add_entry("branch_f3_2", enc_b(13'd8, 5'd1, 5'd2, 3'd2), nop_exp());
        add_entry("addi_neg", enc_i(-12'sd5, 5'd6, 3'd0, 5'd5, 7'd19),
                  make_exp(6, 0, 5, 1, 1, 0, -32'sd5, 0, 1, 0, 3));
        add_entry("slti", enc_i(12'd100, 5'd2, 3'd2, 5'd1, 7'd19),
                  make_exp(2, 0, 1, 2, 1, 0, 32'd100, 0, 1, 2, 3));
        add_entry("sltiu_neg", enc_i(-12'sd1, 5'd4, 3'd3, 5'd3, 7'd19),
                  make_exp(4, 0, 3, 3, 1, 0, 32'hffff_ffff, 0, 1, 2, 3));
        add_entry("xori", enc_i(12'd2047, 5'd8, 3'd4, 5'd7, 7'd19),
                  make_exp(8, 0, 7, 4, 1, 0, 32'd2047, 0, 1, 0, 3));
        add_entry("ori_min", enc_i(12'h800, 5'd10, 3'd6, 5'd9, 7'd19),
                  make_exp(10, 0, 9, 5, 1, 0, 32'hffff_f800, 0, 1, 0, 3));
        add_entry("andi", enc_i(12'h0f0, 5'd12, 3'd7, 5'd11, 7'd19),
                  make_exp(12, 0, 11, 6, 1, 0, 32'h0f0, 0, 1, 0, 3));
        add_entry("slli", enc_i(12'h01f, 5'd14, 3'd1, 5'd13, 7'd19),
                  make_exp(14, 0, 13, 7, 1, 31, 32'h0, 0, 0, 0, 3));
        add_entry("srli", enc_i(12'h001, 5'd16, 3'd5, 5'd15, 7'd19),
                  make_exp(16, 0, 15, 8, 1, 1, 32'h0, 0, 0, 0, 3));
        add_entry("srai", enc_i(12'h407, 5'd18, 3'd5, 5'd17, 7'd19),
                  make_exp(18, 0, 17, 9, 1, 7, 32'h0, 0, 0, 0, 3));
        add_entry("beq", enc_b(13'd8, 5'd2, 5'd1, 3'd0),
                  make_exp(1, 2, 0, 15, 0, 0, 32'd8, 0, 0, 0, 2));
        add_entry("bne_neg", enc_b(-13'sd2, 5'd4, 5'd3, 3'd1),
                  make_exp(3, 4, 0, 16, 0, 0, -32'sd2, 0, 0, 0, 2));
        add_entry("blt_max", enc_b(13'd4094, 5'd6, 5'd5, 3'd4),
                  make_exp(5, 6, 0, 17, 0, 0, 32'd4094, 0, 0, 0, 2));
        add_entry("bge_min", enc_b(13'h1000, 5'd8, 5'd7, 3'd5),
                  make_exp(7, 8, 0, 18, 0, 0, -32'sd4096, 0, 0, 0, 2));
        add_entry("bltu_odd", enc_b(13'd3, 5'd10, 5'd9, 3'd6),    // lsb is dropped
                  make_exp(9, 10, 0, 19, 0, 0, 32'd2, 0, 0, 0, 2));
        add_entry("bgeu", enc_b(13'd100, 5'd12, 5'd11, 3'd7),
                  make_exp(11, 12, 0, 20, 0, 0, 32'd100, 0, 0, 0, 2));
        add_entry("jal_neg", enc_j(-21'sd2, 5'd1),
                  make_exp(0, 0, 1, 0, 1, 0, -32'sd2, 0, 0, 3, 1));
        add_entry("jal_max", enc_j(21'd1048574, 5'd5),
                  make_exp(0, 0, 5, 0, 1, 0, 32'd1048574, 0, 0, 3, 1));
        add_entry("jal_min", enc_j(21'h100000, 5'd31),
                  make_exp(0, 0, 31, 0, 1, 0, -32'sd1048576, 0, 0, 3, 1));
        add_entry("jalr_neg", enc_i(-12'sd8, 5'd2, 3'd0, 5'd1, 7'd103),
                  make_exp(2, 0, 1, 0, 1, 0, -32'sd8, 0, 0, 3, 0));
        add_entry("jalr_pos", enc_i(12'd2047, 5'd3, 3'd0, 5'd6, 7'd103),
                  make_exp(3, 0, 6, 0, 1, 0, 32'd2047, 0, 0, 3, 0));
        add_entry("jalr_bad_f3", enc_i(12'd4, 5'd3, 3'd1, 5'd6, 7'd103), nop_exp());
        add_entry("lui", {20'habcde, 5'd10, 7'd55},
                  make_exp(0, 0, 10, 14, 1, 0, 32'h000a_bcde, 1, 0, 0, 3));
        add_entry("lui_top", {20'hfffff, 5'd1, 7'd55},           // no sign extension
                  make_exp(0, 0, 1, 14, 1, 0, 32'h000f_ffff, 1, 0, 0, 3));
    endtask

    ////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////
    initial begin
        logic [31:0] w;
        int          reset_bad;
        reset     = 1'b1;
        idata     = enc_i(-12'sd5, 5'd6, 3'd0, 5'd5, 7'd19);  // live word during reset
        n_fill    = 0;
        n_pass    = 0;
        n_fail    = 0;
        reset_bad = 0;
        void'($urandom(32'h6380_4cce));
        build_table();
        for (int i = 0; i < NUM_RAND; i++) begin
            w = $urandom;
            w = enc_r({1'b0, w[30], 5'd0}, w[24:20], w[19:15], w[14:12], w[11:7], 7'd51);
            add_entry($sformatf("op_rand_%0d", i), w, op_exp(w));
        end
        for (int k = 0; k < 4; k++) begin
            @(posedge clk);
            if (k == 3) reset <= 1'b0;                       // 4 edges with reset high
            @(negedge clk);
            if (dec !== nop_exp()) begin
                $display("ERROR reset: dec expected %h got %h", nop_exp(), dec);
                reset_bad++;
            end
        end
        if (reset_bad == 0) begin
            n_pass++;
            $display("test reset passed");
        end else begin
            n_fail++;
            $display("test reset failed with %0d errors", reset_bad);
        end
        // words go in back to back, each checked one edge later
        for (int i = 0; i <= NUM_TOTAL; i++) begin
            @(posedge clk);
            if (i < NUM_TOTAL) idata <= word_tab[i];
            @(negedge clk);
            if (i > 0) compare_dec(name_tab[i-1], exp_tab[i-1]);
        end
        $display("tests run %0d, passed %0d, failed %0d", n_pass + n_fail, n_pass, n_fail);
        if (n_fail == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- tb/rv_decoder_assert.sv
`timescale 1ns/1ps
`include "decoder_params.svh"

module rv_decoder_assert (
    input logic                         clk,
    input logic                         reset,
    input decode_ctrl_pkg::decode_out_t dec
);
    import decode_ctrl_pkg::*;

    ////////////////////////////////////////////////////////////////////
    // output bundle properties
    ////////////////////////////////////////////////////////////////////

    // a reset edge leaves the nop bundle behind
    property p_reset_nop;
        @(posedge clk) reset |=> (dec == DECODE_NOP);
    endproperty

    property p_branch_no_write;
        @(posedge clk) disable iff (reset) (dec.pc_sel == PC_BRANCH) |-> !dec.wr;
    endproperty

    property p_imm_rs2_zero;
        @(posedge clk) disable iff (reset) (dec.rs2_sel == RS2_IMM) |-> (dec.rs2 == '0);
    endproperty

    a_reset_nop: assert property (p_reset_nop)
        else $error("dec not nop after reset edge");

    a_branch_no_write: assert property (p_branch_no_write)
        else $error("branch with write enable set");

    a_imm_rs2_zero: assert property (p_imm_rs2_zero)
        else $error("immediate operand with nonzero rs2");

endmodule

bind rv_decoder_top rv_decoder_assert u_decoder_assert (
    .clk   (clk),
    .reset (reset),
    .dec   (dec)
);

//--- rtl/rv_decoder_top.sv
`timescale 1ns/1ps
`include "decoder_params.svh"

module rv_decoder_top (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [`XLEN-1:0]             idata,     // sampled every edge
    output decode_ctrl_pkg::decode_out_t dec        // valid one cycle later
);
    import rv_isa_pkg::*;
    import decode_ctrl_pkg::*;

    inst_t            inst;
    decode_out_t      ctrl;                         // control fields, imm zero
    imm_fmt_e         imm_fmt;
    logic [`XLEN-1:0] imm;
    decode_out_t      dec_next;

    assign inst = inst_t'(idata);

    ctrl_decode u_ctrl_decode (
        .inst    (inst),
        .ctrl    (ctrl),
        .imm_fmt (imm_fmt)
    );

    imm_gen u_imm_gen (
        .inst    (inst),
        .imm_fmt (imm_fmt),
        .imm     (imm)
    );

    //////////////////////////////////////////////////////////////////////
    // merge and output register
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        dec_next     = ctrl;
        dec_next.imm = imm;                         // only field imm_gen owns
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec <= DECODE_NOP;                      // wr low, pc sequential
        end else begin
            dec <= dec_next;
        end
    end

endmodule

//--- rtl/imm_gen.sv
`timescale 1ns/1ps
`include "decoder_params.svh"

module imm_gen (
    input  rv_isa_pkg::inst_t         inst,
    input  decode_ctrl_pkg::imm_fmt_e imm_fmt,
    output logic [`XLEN-1:0]          imm
);
    import decode_ctrl_pkg::*;

    logic [`XLEN-1:0] word;                         // flat view, fields scatter per format

    assign word = inst;

    //////////////////////////////////////////////////////////////////////
    // immediate assembly, sign taken from bit 31
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (imm_fmt)
            IMM_I: begin
                imm = {{(`XLEN-12){word[31]}}, word[31:20]};
            end
            IMM_B: begin
                // offset already doubled by the zero lsb
                imm = {{(`XLEN-12){word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
            end
            IMM_J: begin
                imm = {{(`XLEN-20){word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
            end
            IMM_U: begin
                imm = {{(`XLEN-20){1'b0}}, word[31:12]};    // unshifted upper field
            end
            default: begin
                imm = '0;                           // shifts, OP and nop
            end
        endcase
    end

endmodule

//--- rtl/ctrl_decode.sv
`timescale 1ns/1ps
`include "decoder_params.svh"

module ctrl_decode (
    input  rv_isa_pkg::inst_t            inst,
    output decode_ctrl_pkg::decode_out_t ctrl,      // imm field stays zero
    output decode_ctrl_pkg::imm_fmt_e    imm_fmt
);
    import rv_isa_pkg::*;
    import decode_ctrl_pkg::*;

    alu_op_e br_op;                                 // branch compare, none if illegal

    //////////////////////////////////////////////////////////////////////
    // branch compare from funct3
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (inst.funct3)
            F3_BEQ:  br_op = ALU_BEQ;
            F3_BNE:  br_op = ALU_BNE;
            F3_BLT:  br_op = ALU_BLT;
            F3_BGE:  br_op = ALU_BGE;
            F3_BLTU: br_op = ALU_BLTU;
            F3_BGEU: br_op = ALU_BGEU;
            default: br_op = ALU_NONE;              // funct3 2 and 3
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // main decode, anything not matched falls out as the nop bundle
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        ctrl    = DECODE_NOP;
        imm_fmt = IMM_NONE;
        case (inst.opcode)
            OP: begin
                ctrl.rs1 = inst.rs1;
                ctrl.rs2 = inst.rs2;
                ctrl.rd  = inst.rd;
                ctrl.wr  = 1'b1;
                case (inst.funct3)
                    F3_ADD_SUB: ctrl.alu_op = inst.funct7[5] ? ALU_SUB : ALU_ADD;
                    F3_SLL:     ctrl.alu_op = ALU_SLL;
                    F3_SLT: begin
                        ctrl.alu_op = ALU_SLT;
                        ctrl.rd_sel = RD_CMP;       // write back the flag
                    end
                    F3_SLTU: begin
                        ctrl.alu_op = ALU_SLTU;
                        ctrl.rd_sel = RD_CMP;
                    end
                    F3_XOR:     ctrl.alu_op = ALU_XOR;
                    F3_SRL_SRA: ctrl.alu_op = inst.funct7[5] ? ALU_SRA : ALU_SRL;
                    F3_OR:      ctrl.alu_op = ALU_OR;
                    F3_AND:     ctrl.alu_op = ALU_AND;
                endcase
            end
            OP_IMM: begin
                ctrl.rs1     = inst.rs1;
                ctrl.rd      = inst.rd;
                ctrl.wr      = 1'b1;
                ctrl.rs2_sel = RS2_IMM;             // shifts switch this back
                imm_fmt      = IMM_I;
                case (inst.funct3)
                    F3_ADD_SUB: ctrl.alu_op = ALU_ADD;
                    F3_SLT: begin
                        ctrl.alu_op = ALU_SLT;
                        ctrl.rd_sel = RD_CMP;
                    end
                    F3_SLTU: begin
                        ctrl.alu_op = ALU_SLTU;
                        ctrl.rd_sel = RD_CMP;
                    end
                    F3_XOR:     ctrl.alu_op = ALU_XOR;
                    F3_OR:      ctrl.alu_op = ALU_OR;
                    F3_AND:     ctrl.alu_op = ALU_AND;
                    F3_SLL, F3_SRL_SRA: begin
                        // shift amount sits in the rs2 slot
                        ctrl.rs2_sel = RS2_REG;
                        ctrl.shamt   = inst.rs2[`SHAMT_W-1:0];
                        imm_fmt      = IMM_NONE;
                        if (inst.funct3 == F3_SLL) begin
                            ctrl.alu_op = ALU_SLLI;
                        end else begin
                            ctrl.alu_op = inst.funct7[5] ? ALU_SRAI : ALU_SRLI;
                        end
                    end
                endcase
            end
            LUI: begin
                ctrl.rd      = inst.rd;
                ctrl.wr      = 1'b1;
                ctrl.alu_op  = ALU_LUI;
                ctrl.rs1_sel = RS1_IMM;             // upper field goes straight to alu
                imm_fmt      = IMM_U;
            end
            JAL: begin
                ctrl.rd     = inst.rd;
                ctrl.wr     = 1'b1;
                ctrl.rd_sel = RD_LINK;
                ctrl.pc_sel = PC_JAL;
                imm_fmt     = IMM_J;
            end
            JALR: begin
                if (inst.funct3 == F3_JALR) begin
                    ctrl.rs1    = inst.rs1;
                    ctrl.rd     = inst.rd;
                    ctrl.wr     = 1'b1;
                    ctrl.rd_sel = RD_LINK;
                    ctrl.pc_sel = PC_JALR;
                    imm_fmt     = IMM_I;
                end
            end
            BRANCH: begin
                if (br_op != ALU_NONE) begin        // reserved funct3 stays nop
                    ctrl.rs1    = inst.rs1;
                    ctrl.rs2    = inst.rs2;
                    ctrl.alu_op = br_op;
                    ctrl.pc_sel = PC_BRANCH;        // no writeback, rd stays 0
                    imm_fmt     = IMM_B;
                end
            end
            default: begin
                ctrl    = DECODE_NOP;               // includes the all-zero word
                imm_fmt = IMM_NONE;
            end
        endcase
    end

endmodule

//--- rtl/decode_ctrl_pkg.sv
`include "decoder_params.svh"

package decode_ctrl_pkg;

    //////////////////////////////////////////////////////////////////////
    // alu operation codes
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [`ALU_OP_W-1:0] {
        ALU_NONE = 6'd0,                // no alu work, jumps and nop
        ALU_ADD  = 6'd1,
        ALU_SLT  = 6'd2,
        ALU_SLTU = 6'd3,
        ALU_XOR  = 6'd4,
        ALU_OR   = 6'd5,
        ALU_AND  = 6'd6,
        ALU_SLLI = 6'd7,                // shift by shamt
        ALU_SRLI = 6'd8,
        ALU_SRAI = 6'd9,
        ALU_SUB  = 6'd10,
        ALU_SLL  = 6'd11,               // shift by rs2
        ALU_SRL  = 6'd12,
        ALU_SRA  = 6'd13,
        ALU_LUI  = 6'd14,               // pass immediate through
        ALU_BEQ  = 6'd15,
        ALU_BNE  = 6'd16,
        ALU_BLT  = 6'd17,
        ALU_BGE  = 6'd18,
        ALU_BLTU = 6'd19,
        ALU_BGEU = 6'd20
    } alu_op_e;

    //////////////////////////////////////////////////////////////////////
    // datapath select codes
    //////////////////////////////////////////////////////////////////////
    typedef enum logic {RS1_REG = 1'b0, RS1_IMM = 1'b1} rs1_sel_e;  // imm bypass for lui
    typedef enum logic {RS2_REG = 1'b0, RS2_IMM = 1'b1} rs2_sel_e;

    typedef enum logic [1:0] {
        RD_ALU  = 2'd0,                 // alu result
        RD_CMP  = 2'd2,                 // set-less-than flag
        RD_LINK = 2'd3                  // pc + 4
    } rd_sel_e;

    typedef enum logic [1:0] {
        PC_JALR   = 2'd0,
        PC_JAL    = 2'd1,
        PC_BRANCH = 2'd2,
        PC_SEQ    = 2'd3                // pc + 4
    } pc_sel_e;

    typedef enum logic [2:0] {IMM_NONE, IMM_I, IMM_B, IMM_J, IMM_U} imm_fmt_e;

    // registered decoder output
    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rd;
        alu_op_e                alu_op;
        logic                   wr;     // register file write enable
        logic [`SHAMT_W-1:0]    shamt;
        logic [`XLEN-1:0]       imm;
        rs1_sel_e               rs1_sel;
        rs2_sel_e               rs2_sel;
        rd_sel_e                rd_sel;
        pc_sel_e                pc_sel;
    } decode_out_t;

    localparam decode_out_t DECODE_NOP = '{
        rs1: '0, rs2: '0, rd: '0, alu_op: ALU_NONE, wr: 1'b0, shamt: '0, imm: '0,
        rs1_sel: RS1_REG, rs2_sel: RS2_REG, rd_sel: RD_ALU, pc_sel: PC_SEQ
    };

endpackage

//--- rtl/rv_isa_pkg.sv
`include "decoder_params.svh"

package rv_isa_pkg;

    //////////////////////////////////////////////////////////////////////
    // major opcodes, bits 6:0 of the word
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [6:0] {
        OP     = 7'd51,                 // register-register alu
        OP_IMM = 7'd19,                 // register-immediate alu and shifts
        LUI    = 7'd55,                 // load upper immediate
        JAL    = 7'd111,                // jump and link
        JALR   = 7'd103,                // jump and link register
        BRANCH = 7'd99                  // conditional branches
    } opcode_e;

    typedef logic [2:0] funct3_t;

    // funct3 for OP and OP_IMM
    localparam funct3_t F3_ADD_SUB = 3'd0;  // add/sub, addi
    localparam funct3_t F3_SLL     = 3'd1;
    localparam funct3_t F3_SLT     = 3'd2;
    localparam funct3_t F3_SLTU    = 3'd3;
    localparam funct3_t F3_XOR     = 3'd4;
    localparam funct3_t F3_SRL_SRA = 3'd5;  // bit 30 picks arithmetic
    localparam funct3_t F3_OR      = 3'd6;
    localparam funct3_t F3_AND     = 3'd7;

    // funct3 for BRANCH, 2 and 3 are not defined
    localparam funct3_t F3_BEQ  = 3'd0;
    localparam funct3_t F3_BNE  = 3'd1;
    localparam funct3_t F3_BLT  = 3'd4;
    localparam funct3_t F3_BGE  = 3'd5;
    localparam funct3_t F3_BLTU = 3'd6;
    localparam funct3_t F3_BGEU = 3'd7;

    localparam funct3_t F3_JALR = 3'd0;     // only legal jalr encoding

    // R-type field layout, other formats reuse the same bit positions
    typedef struct packed {
        logic [6:0]             funct7;     // bit 30 is funct7[5]
        logic [`REG_ADDR_W-1:0] rs2;        // also shamt for immediate shifts
        logic [`REG_ADDR_W-1:0] rs1;
        funct3_t                funct3;
        logic [`REG_ADDR_W-1:0] rd;
        opcode_e                opcode;
    } inst_t;

endpackage

//--- rtl/decoder_params.svh
`ifndef DECODER_PARAMS_SVH
`define DECODER_PARAMS_SVH

// instruction word and immediate width
`define XLEN        32

// register file index, x0..x31
`define REG_ADDR_W  5

// ALU operation code, room for the 21 ops plus spares
`define ALU_OP_W    6

// immediate shift amount, 5 bits on RV32
`define SHAMT_W     5

`endif
